// File: logic/simon_pkg.sv
/*
 * Game-level types and constants for the Simon puzzle module.
 * Round states, color codes and the sequence LFSR step live here.
 * Import with a wildcard in the module header.
 */
package simon_pkg;

    localparam int NUM_STAGES = 5;                  // colors in one game
    localparam int SEQ_W = 2 * NUM_STAGES;          // width of the packed sequence bus
    localparam logic [7:0] LFSR_TAPS = 8'hB8;       // galois feedback mask

    typedef enum logic [1:0] {
        BLUE   = 2'd0,
        YELLOW = 2'd1,
        GREEN  = 2'd2,
        RED    = 2'd3
    } color_t;

    // display and input states alternate, Dk = 2(k-1), Ik = 2(k-1)+1
    typedef enum logic [3:0] {
        D1 = 4'd0, I1 = 4'd1,
        D2 = 4'd2, I2 = 4'd3,
        D3 = 4'd4, I3 = 4'd5,
        D4 = 4'd6, I4 = 4'd7,
        D5 = 4'd8, I5 = 4'd9,
        IDLE = 4'd15
    } round_state_t;

    function automatic logic is_display(input round_state_t s);
        logic [3:0] v;
        v = s;
        return (v <= 4'd8) && !v[0];
    endfunction

    function automatic logic is_input(input round_state_t s);
        logic [3:0] v;
        v = s;
        return (v <= 4'd9) && v[0];
    endfunction

    // stage number k of a Dk/Ik state, 0 otherwise
    function automatic logic [2:0] stage_of(input round_state_t s);
        logic [3:0] v;
        v = s;
        return (v <= 4'd9) ? 3'(v[3:1] + 3'd1) : 3'd0;
    endfunction

    // one right shift, taps applied when the bit shifted out is 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

endpackage

// File: logic/panel_pkg.sv
/*
 * Panel-side codes shared by the game blocks.
 * One-hot button codes, light codes and the button-to-color map.
 */
package panel_pkg;
    import simon_pkg::*;

    typedef logic [5:0] btn_t;

    localparam btn_t BTN_NO_PRESS = 6'b000000;
    localparam btn_t BTN_SELECT   = 6'b000001;
    localparam btn_t BTN_UP       = 6'b000010;
    localparam btn_t BTN_RIGHT    = 6'b000100;
    localparam btn_t BTN_DOWN     = 6'b001000;
    localparam btn_t BTN_LEFT     = 6'b010000;
    localparam btn_t BTN_BACK     = 6'b100000;

    localparam logic [3:0] LIGHT_OFF = 4'b0000;
    localparam logic [3:0] LIGHT_ALL = 4'b1111;   // shown once the module is cleared

    function automatic logic is_color_btn(input btn_t b);
        return (b == BTN_UP) || (b == BTN_RIGHT) || (b == BTN_DOWN) || (b == BTN_LEFT);
    endfunction

    // UP blue, RIGHT yellow, DOWN green, LEFT red
    function automatic color_t btn_color(input btn_t b);
        color_t c;
        case (b)
            BTN_RIGHT: c = YELLOW;
            BTN_DOWN:  c = GREEN;
            BTN_LEFT:  c = RED;
            default:   c = BLUE;
        endcase
        return c;
    endfunction

    function automatic logic [3:0] color_light(input color_t c);
        return 4'b0001 << c;
    endfunction

    function automatic logic [3:0] btn_light(input btn_t b);
        return is_color_btn(b) ? color_light(btn_color(b)) : LIGHT_OFF;
    endfunction

endpackage

// File: logic/simon_if.sv
/*
 * Interfaces between the Simon blocks.
 * seq_wr_if carries color writes into the sequence store,
 * round_if carries round state, strobe and sequence to the lights.
 */
`timescale 1ns/1ps

interface seq_wr_if
    import simon_pkg::*;
();
    logic   wr_valid;
    color_t wr_color;
    logic   clear;      // one cycle, wins over a write
    logic   wr_ready;
    logic   full;

    modport gen   (output wr_valid, wr_color, clear, input wr_ready);
    modport store (input wr_valid, wr_color, clear, output wr_ready, full);
endinterface

interface round_if
    import simon_pkg::*;
();
    round_state_t     state;
    logic             s_strobe;
    logic             cleared;
    logic [SEQ_W-1:0] seq_bus;   // color i at bits 2i+1..2i

    modport ctrl  (output state, s_strobe, cleared, input seq_bus);
    modport light (input state, s_strobe, cleared, seq_bus);
endinterface

// File: logic/simon_sequence_gen.sv
/*
 * Sequence generator. On start it clears the store, then writes
 * NUM_STAGES colors drawn from a free-running 8-bit Galois LFSR.
 */
`timescale 1ns/1ps

module simon_sequence_gen
    import simon_pkg::*;
#(
    parameter logic [7:0] LFSR_SEED = 8'h5A
) (
    input  logic  clk,
    input  logic  nrst,
    input  logic  start,
    seq_wr_if.gen wr
);
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_CLEAR,
        GEN_WRITE
    } gen_state_t;

    gen_state_t state;
    logic [7:0] lfsr;
    logic [7:0] lfsr_one;       // after the first step
    logic [7:0] lfsr_two;       // after the second step
    logic [2:0] sent;
    logic       accept;

    assign lfsr_one = lfsr_step(lfsr);
    assign lfsr_two = lfsr_step(lfsr_one);
    assign accept = wr.wr_valid && wr.wr_ready;

    assign wr.clear = (state == GEN_CLEAR);
    assign wr.wr_valid = (state == GEN_WRITE);
    assign wr.wr_color = color_t'({lfsr_one[0], lfsr[0]});   // first bit out is the low bit

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= GEN_IDLE;
            lfsr <= LFSR_SEED;
            sent <= 3'd0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (start) state <= GEN_CLEAR;
                end
                GEN_CLEAR: begin
                    sent <= 3'd0;
                    state <= GEN_WRITE;
                end
                GEN_WRITE: begin
                    if (accept) begin
                        lfsr <= lfsr_two;           // lfsr only moves on a taken color
                        if (sent == 3'(NUM_STAGES - 1)) begin
                            state <= GEN_IDLE;
                        end else begin
                            sent <= sent + 3'd1;
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

endmodule

// File: logic/simon_sequence_store.sv
/*
 * Sequence store. Holds the NUM_STAGES colors of the current game
 * and presents them packed on seq_bus, color i at bits 2i+1..2i.
 */
`timescale 1ns/1ps

module simon_sequence_store
    import simon_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    seq_wr_if.store          wr,
    output logic [SEQ_W-1:0] seq_bus
);
    color_t     slots [NUM_STAGES];
    logic [2:0] fill_cnt;       // also the slot the next write lands in
    logic       wr_en;

    assign wr.full = (fill_cnt == 3'(NUM_STAGES));
    assign wr.wr_ready = !wr.full;
    assign wr_en = !wr.clear && wr.wr_valid && wr.wr_ready;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            fill_cnt <= 3'd0;
        end else if (wr.clear) begin
            fill_cnt <= 3'd0;
        end else if (wr_en) begin
            fill_cnt <= fill_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) slots[fill_cnt] <= wr.wr_color;
    end

    genvar i;
    generate
        for (i = 0; i < NUM_STAGES; i++) begin : g_pack
            assign seq_bus[2*i +: 2] = slots[i];
        end
    endgenerate

endmodule

// File: logic/simon_round_ctrl.sv
/*
 * Round controller. Owns the strobe divider and the D/I state sequence,
 * starts the generator on SELECT and checks each color press against
 * the stored sequence, raising cleared or lost.
 */
`timescale 1ns/1ps

module simon_round_ctrl
    import simon_pkg::*;
    import panel_pkg::*;
#(
    parameter int STROBE_DIV = 50
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic [5:0] button,
    input  logic       full,
    output logic       start,
    round_if.ctrl      rnd,
    output logic       lost,
    output logic [2:0] stage
);
    localparam int DIV_W = (STROBE_DIV > 1) ? $clog2(STROBE_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    btn_t             btn_s1;
    btn_t             btn_s2;
    btn_t             btn_prev;
    btn_t             rise;
    logic             sel_edge;
    logic             color_edge;
    color_t           press_color;
    color_t           want_color;
    logic             loading;      // waiting for the store to fill
    logic [1:0]       load_wait;    // skips the stale full of the last game
    logic [3:0]       disp_cnt;     // strobes seen in this display state
    logic [2:0]       press_idx;    // correct presses so far in this stage

    always_ff @(posedge clk) begin
        if (!nrst) begin
            btn_s1 <= BTN_NO_PRESS;
            btn_s2 <= BTN_NO_PRESS;
            btn_prev <= BTN_NO_PRESS;
        end else begin
            btn_s1 <= button;
            btn_s2 <= btn_s1;
            btn_prev <= btn_s2;
        end
    end

    assign rise = btn_s2 & ~btn_prev;
    assign sel_edge = (rise == BTN_SELECT);
    assign color_edge = is_color_btn(rise);     // several buttons at once are ignored
    assign press_color = btn_color(rise);
    assign want_color = color_t'(rnd.seq_bus[2*press_idx +: 2]);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            div_cnt <= '0;
        end else if (div_cnt == DIV_W'(STROBE_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    assign rnd.s_strobe = (div_cnt == DIV_W'(STROBE_DIV - 1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rnd.state <= IDLE;
            rnd.cleared <= 1'b0;
            lost <= 1'b0;
            stage <= 3'd0;
            start <= 1'b0;
            loading <= 1'b0;
            load_wait <= 2'd0;
            disp_cnt <= 4'd0;
            press_idx <= 3'd0;
        end else begin
            start <= 1'b0;
            if (rnd.state == IDLE) begin
                if (loading) begin
                    if (load_wait != 2'd0) begin
                        load_wait <= load_wait - 2'd1;
                    end else if (full) begin
                        loading <= 1'b0;
                        rnd.state <= D1;
                        stage <= 3'd1;
                        disp_cnt <= 4'd0;
                    end
                end else if (sel_edge) begin
                    start <= 1'b1;
                    loading <= 1'b1;
                    load_wait <= 2'd2;
                    rnd.cleared <= 1'b0;
                    lost <= 1'b0;
                    stage <= 3'd0;
                end
            end else if (is_display(rnd.state)) begin
                // 3 pause strobes, k lights, then the off strobe ends the display
                if (rnd.s_strobe) begin
                    if (disp_cnt == {1'b0, stage} + 4'd3) begin
                        rnd.state <= round_state_t'(rnd.state + 4'd1);
                        press_idx <= 3'd0;
                    end else begin
                        disp_cnt <= disp_cnt + 4'd1;
                    end
                end
            end else if (is_input(rnd.state) && color_edge) begin
                if (press_color != want_color) begin
                    lost <= 1'b1;
                    rnd.state <= IDLE;
                end else if (press_idx == stage - 3'd1) begin
                    press_idx <= 3'd0;
                    if (stage == 3'(NUM_STAGES)) begin
                        rnd.cleared <= 1'b1;
                        rnd.state <= IDLE;
                    end else begin
                        rnd.state <= round_state_t'(rnd.state + 4'd1);
                        stage <= stage + 3'd1;
                        disp_cnt <= 4'd0;
                    end
                end else begin
                    press_idx <= press_idx + 3'd1;
                end
            end
        end
    end

endmodule

// File: logic/simon_light_control.sv
/*
 * Light control for the four virtual lights. Plays the stored sequence
 * during display states, one color per strobe after a three-strobe pause,
 * and mirrors the raw direction button on the manual lights.
 */
`timescale 1ns/1ps

module simon_light_control
    import simon_pkg::*;
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    round_if.light     rnd,
    input  logic [5:0] button,
    output logic [3:0] light_seq,
    output logic [3:0] light_manual
);
    logic [1:0] wait_cnt;       // pause strobes seen
    logic [2:0] light_cnt;      // colors shown so far
    logic [2:0] k;
    color_t     cur_color;

    assign k = stage_of(rnd.state);
    assign cur_color = color_t'(rnd.seq_bus[2*light_cnt +: 2]);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            light_seq <= LIGHT_OFF;
            wait_cnt <= 2'd0;
            light_cnt <= 3'd0;
        end else if (rnd.cleared) begin
            light_seq <= LIGHT_ALL;
            wait_cnt <= 2'd0;
            light_cnt <= 3'd0;
        end else if (is_display(rnd.state)) begin
            if (rnd.s_strobe) begin
                if (wait_cnt != 2'd3) begin
                    wait_cnt <= wait_cnt + 2'd1;
                    light_seq <= LIGHT_OFF;
                end else if (light_cnt < k) begin
                    light_seq <= color_light(cur_color);   // replaces the previous color
                    light_cnt <= light_cnt + 3'd1;
                end else begin
                    light_seq <= LIGHT_OFF;                 // off strobe, display is over
                    wait_cnt <= 2'd0;
                    light_cnt <= 3'd0;
                end
            end
        end else begin
            // input states and idle keep the lights dark
            light_seq <= LIGHT_OFF;
            wait_cnt <= 2'd0;
            light_cnt <= 3'd0;
        end
    end

    // raw button, no sync, so the light follows the finger
    assign light_manual = btn_light(btn_t'(button));

endmodule

// File: logic/simon_top.sv
/*
 * Top of the Simon puzzle module. Connects generator, store,
 * round controller and light control. Plain ports to the panel.
 */
`timescale 1ns/1ps

module simon_top #(
    parameter int         STROBE_DIV = 50,
    parameter logic [7:0] LFSR_SEED  = 8'h5A
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic [5:0] button,          // raw, unsynchronized
    output logic [3:0] light_seq,
    output logic [3:0] light_manual,
    output logic       cleared,
    output logic       lost,
    output logic [2:0] stage
);
    logic start;

    seq_wr_if wr_if ();
    round_if  rnd_if ();

    simon_sequence_gen #(
        .LFSR_SEED (LFSR_SEED)
    ) u_gen (
        .clk   (clk),
        .nrst  (nrst),
        .start (start),
        .wr    (wr_if.gen)
    );

    simon_sequence_store u_store (
        .clk     (clk),
        .nrst    (nrst),
        .wr      (wr_if.store),
        .seq_bus (rnd_if.seq_bus)
    );

    simon_round_ctrl #(
        .STROBE_DIV (STROBE_DIV)
    ) u_ctrl (
        .clk    (clk),
        .nrst   (nrst),
        .button (button),
        .full   (wr_if.full),
        .start  (start),
        .rnd    (rnd_if.ctrl),
        .lost   (lost),
        .stage  (stage)
    );

    simon_light_control u_light (
        .clk          (clk),
        .nrst         (nrst),
        .rnd          (rnd_if.light),
        .button       (button),
        .light_seq    (light_seq),
        .light_manual (light_manual)
    );

    assign cleared = rnd_if.cleared;

endmodule

// File: verif/simon_tb_model.svh
/*
 * Reference model for the Simon testbench, included inside simon_tb.
 * Gives the color sequence of each game, the light and button codes
 * and the 8-bit Galois step used by the model and the stimulus.
 */
`ifndef SIMON_TB_MODEL_SVH
`define SIMON_TB_MODEL_SVH

// shifts right and applies mask 0xB8 when a 1 falls out
function automatic logic [7:0] galois_step(input logic [7:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 8'hB8;
    end
    return s >> 1;
endfunction

// packs the colors of one game with color i at bits 2i+1..2i
// ten LFSR steps per game
function automatic logic [9:0] expected_sequence(input logic [7:0] seed, input int game);
    logic [7:0] s;
    logic [9:0] seq;
    int n;
    s = seed;
    seq = '0;
    for (n = 0; n < game * 10; n++) begin
        s = galois_step(s);
    end
    for (n = 0; n < 5; n++) begin
        seq[2*n] = s[0];            // first bit out is the low bit
        s = galois_step(s);
        seq[2*n+1] = s[0];
        s = galois_step(s);
    end
    return seq;
endfunction

// blue, yellow, green and red on lights 0 to 3
function automatic logic [3:0] expected_light(input logic [1:0] c);
    case (c)
        2'd0:    return 4'b0001;
        2'd1:    return 4'b0010;
        2'd2:    return 4'b0100;
        default: return 4'b1000;
    endcase
endfunction

// one light per single direction button and dark for anything else
function automatic logic [3:0] expected_manual(input logic [5:0] b);
    case (b)
        6'b000010: return 4'b0001;
        6'b000100: return 4'b0010;
        6'b001000: return 4'b0100;
        6'b010000: return 4'b1000;
        default:   return 4'b0000;
    endcase
endfunction

function automatic logic [5:0] button_for_color(input logic [1:0] c);
    return 6'b000010 << c;          // UP blue .. LEFT red
endfunction

`endif

// File: verif/simon_tb.sv
/*
 * Testbench for the Simon puzzle module. Checks reset values and the
 * manual lights, then plays three games against simon_top with a short
 * strobe period: a cleared game, a lost game and a continuation game.
 */
`timescale 1ns/1ps

module simon_tb;
    localparam int         STROBE_DIV  = 4;
    localparam logic [7:0] LFSR_SEED   = 8'h5A;
    localparam int         STAGES      = 5;
    localparam int         WATCHDOG_NS = 6 * 40 * STROBE_DIV * 100;
    localparam int         WAIT_CYCLES = 20 * STROBE_DIV;   // longest display is 9 strobes

    logic       clk;
    logic       nrst;
    logic [5:0] button;
    logic [3:0] light_seq;
    logic [3:0] light_manual;
    logic       cleared;
    logic       lost;
    logic [2:0] stage;

    logic [7:0] tb_lfsr;
    logic [3:0] seen [$];       // sequence lights in display order
    logic [3:0] prev_light;
    logic       cleared_d;
    int         hold_cnt;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;

    `include "simon_tb_model.svh"

    simon_top #(
        .STROBE_DIV (STROBE_DIV),
        .LFSR_SEED  (LFSR_SEED)
    ) uut (
        .clk          (clk),
        .nrst         (nrst),
        .button       (button),
        .light_seq    (light_seq),
        .light_manual (light_manual),
        .cleared      (cleared),
        .lost         (lost),
        .stage        (stage)
    );

    always #50 clk = ~clk;

    function automatic logic draw_bit();
        logic b;
        b = tb_lfsr[0];
        tb_lfsr = galois_step(tb_lfsr);
        return b;
    endfunction

    // compare process, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (nrst) begin
            checks++;
            if (light_manual !== expected_manual(button)) begin
                errors++;
                $display("MISMATCH at %0t: light_manual %b for button %b, expected %b",
                         $time, light_manual, button, expected_manual(button));
            end
            if (!cleared && !cleared_d) begin
                // each lit value lasts one strobe, so repeats are split by hold time
                if (light_seq !== prev_light) begin
                    hold_cnt = 1;
                    if (light_seq != 4'b0000) seen.push_back(light_seq);
                end else begin
                    hold_cnt++;
                    if (hold_cnt > STROBE_DIV) begin
                        hold_cnt = 1;
                        if (light_seq != 4'b0000) seen.push_back(light_seq);
                    end
                end
                if (light_seq != 4'b0000 && $countones(light_seq) != 1) begin
                    errors++;
                    $display("MISMATCH at %0t: light_seq %b is not one-hot", $time, light_seq);
                end
            end
            prev_light = light_seq;
            cleared_d = cleared;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic press(input logic [5:0] b);
        button = b;
        next_cycle();
        next_cycle();               // held two cycles
        button = 6'b000000;
        next_cycle();
        next_cycle();
    endtask

    task automatic check_display(input int game, input int k);
        logic [9:0] seq;
        int waited;
        int i;
        seq = expected_sequence(LFSR_SEED, game);
        waited = 0;
        while (seen.size() < k && waited < WAIT_CYCLES) begin
            next_cycle();
            waited++;
        end
        while (light_seq != 4'b0000 && waited < WAIT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (waited >= WAIT_CYCLES) begin
            errors++;
            $display("game %0d stage %0d: display did not end within %0d cycles",
                     game + 1, k, WAIT_CYCLES);
        end
        checks++;
        if (seen.size() != k) begin
            errors++;
            $display("MISMATCH at %0t: %0d lights shown in stage %0d, expected %0d",
                     $time, seen.size(), k, k);
        end
        for (i = 0; i < k && i < seen.size(); i++) begin
            checks++;
            if (seen[i] !== expected_light(seq[2*i +: 2])) begin
                errors++;
                $display("MISMATCH at %0t: game %0d light %0d is %b, expected %b",
                         $time, game + 1, i, seen[i], expected_light(seq[2*i +: 2]));
            end
        end
        seen.delete();
    endtask

    // wrong_stage 0 plays every stage correctly
    task automatic play_game(input int game, input int wrong_stage);
        logic [9:0] seq;
        logic [1:0] c;
        logic [1:0] off;
        int wrong_idx;
        int k;
        int i;
        bit gone_wrong;
        seq = expected_sequence(LFSR_SEED, game);
        gone_wrong = 0;
        seen.delete();
        press(6'b000001);           // SELECT
        for (k = 1; k <= STAGES && !gone_wrong; k++) begin
            check_display(game, k);
            checks++;
            if (stage !== 3'(k)) begin
                errors++;
                $display("MISMATCH at %0t: stage %0d, expected %0d", $time, stage, k);
            end
            wrong_idx = (k == wrong_stage) ? int'(draw_bit()) % k : -1;
            for (i = 0; i < k && !gone_wrong; i++) begin
                c = seq[2*i +: 2];
                checks++;
                if (light_seq !== 4'b0000) begin
                    errors++;
                    $display("MISMATCH at %0t: light_seq %b during input", $time, light_seq);
                end
                if (i == wrong_idx) begin
                    off[0] = draw_bit();
                    off[1] = draw_bit();
                    c = c + 2'd1 + ((off == 2'd3) ? 2'd0 : off);   // offset 1..3
                    gone_wrong = 1;
                end
                press(button_for_color(c));
            end
        end
    endtask

    task automatic wait_flag(input bit want_lost);
        int waited;
        waited = 0;
        while (!(want_lost ? lost : cleared) && waited < WAIT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (waited >= WAIT_CYCLES) begin
            errors++;
            $display("%s was never raised", want_lost ? "lost" : "cleared");
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_flags(input bit exp_cleared, input bit exp_lost, input logic [3:0] exp_light);
        checks++;
        if (cleared !== exp_cleared || lost !== exp_lost || light_seq !== exp_light) begin
            errors++;
            $display("MISMATCH at %0t: cleared %b lost %b light_seq %b, expected %b %b %b",
                     $time, cleared, lost, light_seq, exp_cleared, exp_lost, exp_light);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int err_before;
        int i;
        logic [5:0] pats [8];
        pats = '{6'b000010, 6'b000100, 6'b001000, 6'b010000,
                 6'b100000, 6'b000000, 6'b001010, 6'b010111};
        clk = 1'b0;
        nrst = 1'b0;
        button = 6'b000000;
        tb_lfsr = 8'd91;
        prev_light = 4'b0000;
        cleared_d = 1'b0;
        hold_cnt = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        #10;
        nrst = 1'b1;

        err_before = errors;
        check_flags(1'b0, 1'b0, 4'b0000);
        checks++;
        if (stage !== 3'd0) begin
            errors++;
            $display("MISMATCH at %0t: stage %0d after reset, expected 0", $time, stage);
        end
        finish_test("reset values", err_before);

        err_before = errors;
        for (i = 0; i < 8; i++) begin
            button = pats[i];
            next_cycle();
            checks++;
            if (light_manual !== expected_manual(pats[i])) begin
                errors++;
                $display("MISMATCH at %0t: light_manual %b for %b", $time, light_manual, pats[i]);
            end
        end
        button = 6'b000000;
        repeat (4) next_cycle();
        finish_test("manual lights", err_before);

        err_before = errors;
        play_game(0, 0);
        wait_flag(1'b0);
        next_cycle();
        check_flags(1'b1, 1'b0, 4'b1111);
        finish_test("first game cleared", err_before);

        err_before = errors;
        play_game(1, 2);
        wait_flag(1'b1);
        next_cycle();
        check_flags(1'b0, 1'b1, 4'b0000);
        checks++;
        if (stage !== 3'd2) begin
            errors++;
            $display("MISMATCH at %0t: stage %0d after loss, expected 2", $time, stage);
        end
        finish_test("second game lost", err_before);

        err_before = errors;
        play_game(2, 0);
        wait_flag(1'b0);
        next_cycle();
        check_flags(1'b1, 1'b0, 4'b1111);
        finish_test("third game sequence", err_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
logic/simon_pkg.sv
logic/panel_pkg.sv
logic/simon_if.sv
logic/simon_sequence_gen.sv
logic/simon_sequence_store.sv
logic/simon_round_ctrl.sv
logic/simon_light_control.sv
logic/simon_top.sv
verif/simon_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the Simon testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module simon_tb -f compile.f -o simon_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simon_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
